// File: design/rename_pkg.sv
// Shared sizes, index types and payload structs for the rename stage
// Every rename module refers to these by scoped name
// Covers the decode request, the registered rename result and the
// single-register strobes used for writeback and commit-free
`default_nettype none

package rename_pkg;

    // Architectural and physical register file sizes
    localparam int NUM_AREGS = 32;
    localparam int NUM_PREGS = 64;

    // Index widths
    localparam int AREG_W = 5;
    localparam int PREG_W = 6;

    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [PREG_W-1:0] preg_t;

    // Decode request, one instruction per handshake
    typedef struct packed {
        areg_t rs1;
        areg_t rs2;
        areg_t rd;
    } rename_req_t;

    // Rename result, held stable while ack is high
    typedef struct packed {
        preg_t prs1;
        preg_t prs2;
        logic  rs1_ready;
        logic  rs2_ready;
        preg_t prd;
        preg_t old_prd;   // freed later by the reorder buffer
    } rename_rsp_t;

    // One-cycle strobe naming one physical register
    // Used for writeback and for commit-free
    typedef struct packed {
        logic  en;
        preg_t preg;
    } preg_strobe_t;

endpackage

`default_nettype wire

// File: design/free_list.sv
// Free list of physical registers for the rename stage
// Circular FIFO, head supplies the next register to allocate
// Commit pushes old mappings back at the tail
// Comes out of reset holding p1 through p63 in order, p0 is never present
// Push and pop may happen in the same cycle
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  wire                      clk_i,
    input  wire                      reset_i,
    input  wire                      alloc_i,
    input  rename_pkg::preg_strobe_t free_i,
    output logic                     empty_o,
    output rename_pkg::preg_t        head_preg_o
);

    // Storage, one slot per physical register
    rename_pkg::preg_t fifo_q [rename_pkg::NUM_PREGS];

    // Pointers wrap naturally at 64 entries
    rename_pkg::preg_t head_q;
    rename_pkg::preg_t tail_q;

    // Count needs one bit more than the pointers
    logic [rename_pkg::PREG_W:0] count_q;

    logic push;
    logic pop;
    logic full;

    assign push = free_i.en;
    assign pop  = alloc_i;

    assign empty_o     = (count_q == '0);
    assign full        = (count_q == rename_pkg::NUM_PREGS);
    assign head_preg_o = fifo_q[head_q];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Slots 0..62 hold p1..p63, last slot is filled by the first push
            for (int i = 0; i < rename_pkg::NUM_PREGS - 1; i++) begin
                fifo_q[i] <= rename_pkg::preg_t'(i + 1);
            end
            head_q  <= '0;
            tail_q  <= rename_pkg::preg_t'(rename_pkg::NUM_PREGS - 1);
            count_q <= (rename_pkg::PREG_W + 1)'(rename_pkg::NUM_PREGS - 1);
        end else begin
            if (push) begin
                fifo_q[tail_q] <= free_i.preg;
                tail_q         <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            // Both at once leaves the count alone
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Controller must hold off allocation while empty
    a_no_pop_empty: assert property (
        @(posedge clk_i) disable iff (reset_i) pop |-> !empty_o
    ) else $error("free list popped while empty");

    // Only 63 registers circulate, so a full list cannot take a push
    a_no_push_full: assert property (
        @(posedge clk_i) disable iff (reset_i) push |-> (!full || pop)
    ) else $error("free list pushed while full");

    // p0 is hardwired to x0 and must never circulate
    a_no_push_p0: assert property (
        @(posedge clk_i) disable iff (reset_i) push |-> (free_i.preg != '0)
    ) else $error("p0 pushed onto free list");

endmodule

`default_nettype wire

// File: design/map_table.sv
// Register alias table for the rename stage
// Maps each architectural register to its current physical register
// Two source lookups and one destination lookup, all combinational
// One write port, lands at the clock edge so an instruction's sources
// see the mapping from before its own destination update
// x0 is pinned to p0, writes to it are dropped
`timescale 1ns/1ps
`default_nettype none

module map_table (
    input  wire                clk_i,
    input  wire                reset_i,
    input  rename_pkg::areg_t  rs1_i,
    input  rename_pkg::areg_t  rs2_i,
    input  rename_pkg::areg_t  rd_i,
    input  wire                we_i,
    input  rename_pkg::preg_t  wdata_i,
    output rename_pkg::preg_t  rs1_preg_o,
    output rename_pkg::preg_t  rs2_preg_o,
    output rename_pkg::preg_t  rd_preg_o
);

    // One physical index per architectural register
    rename_pkg::preg_t map_q [rename_pkg::NUM_AREGS];

    // Write enable after the x0 filter
    logic write_en;

    assign write_en = we_i && (rd_i != '0);

    // Source lookups
    assign rs1_preg_o = map_q[rs1_i];
    assign rs2_preg_o = map_q[rs2_i];

    // Previous mapping of the destination
    // Reported as old_prd and freed at commit
    assign rd_preg_o = map_q[rd_i];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Everything starts on p0, always ready
            for (int i = 0; i < rename_pkg::NUM_AREGS; i++) begin
                map_q[i] <= '0;
            end
        end else if (write_en) begin
            map_q[rd_i] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

// File: design/busy_table.sv
// Busy table for the rename stage
// One bit per physical register, set while a result is still pending
// Allocation sets the bit, writeback clears it
// Reads bypass a writeback arriving in the same cycle
`timescale 1ns/1ps
`default_nettype none

module busy_table (
    input  wire                      clk_i,
    input  wire                      reset_i,
    input  wire                      set_i,
    input  rename_pkg::preg_t        set_preg_i,
    input  rename_pkg::preg_strobe_t wb_i,
    input  rename_pkg::preg_t        rd1_preg_i,
    input  rename_pkg::preg_t        rd2_preg_i,
    output logic                     rd1_ready_o,
    output logic                     rd2_ready_o
);

    logic [rename_pkg::NUM_PREGS-1:0] busy_q;

    // Ready if p0, not busy, or being written back right now
    function automatic logic ready_of(rename_pkg::preg_t p);
        logic wb_hit;
        wb_hit   = wb_i.en && (wb_i.preg == p);
        ready_of = (p == '0) || !busy_q[p] || wb_hit;
    endfunction

    assign rd1_ready_o = ready_of(rd1_preg_i);
    assign rd2_ready_o = ready_of(rd2_preg_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= '0;
        end else begin
            if (wb_i.en) begin
                busy_q[wb_i.preg] <= 1'b0;
            end
            // New allocation wins over a stale writeback to the same register
            if (set_i) begin
                busy_q[set_preg_i] <= 1'b1;
            end
        end
    end

    // Free list never hands out p0
    a_no_set_p0: assert property (
        @(posedge clk_i) disable iff (reset_i) set_i |-> (set_preg_i != '0)
    ) else $error("busy set targets p0");

endmodule

`default_nettype wire

// File: design/rename_ctrl.sv
// Handshake controller for the rename stage
// Runs the four-phase req/ack exchange with decode
// Decides the cycle a rename fires and captures the full result then
// Stalls with ack low while a real destination finds the free list empty
// Result is held in a register so it stays put while ack is high
`timescale 1ns/1ps
`default_nettype none

module rename_ctrl (
    input  wire                     clk_i,
    input  wire                     reset_i,
    input  wire                     req_i,
    input  rename_pkg::rename_req_t req_data_i,
    input  wire                     fl_empty_i,
    input  rename_pkg::preg_t       alloc_preg_i,
    input  rename_pkg::preg_t       map_rs1_i,
    input  rename_pkg::preg_t       map_rs2_i,
    input  rename_pkg::preg_t       map_rd_i,
    input  wire                     rs1_ready_i,
    input  wire                     rs2_ready_i,
    output logic                    ack_o,
    output rename_pkg::rename_rsp_t rsp_o,
    output logic                    fire_o,
    output logic                    alloc_o
);

    typedef enum logic {
        IDLE,
        ACKED
    } state_t;

    state_t                  state_q;
    rename_pkg::rename_rsp_t rsp_q;
    rename_pkg::rename_rsp_t rsp_d;
    logic                    rd_is_x0;

    assign rd_is_x0 = (req_data_i.rd == '0);

    // x0 destinations need no free register
    assign fire_o  = (state_q == IDLE) && req_i && (rd_is_x0 || !fl_empty_i);
    assign alloc_o = fire_o && !rd_is_x0;

    // Result assembled from this cycle's lookups
    always_comb begin
        rsp_d.prs1      = map_rs1_i;
        rsp_d.prs2      = map_rs2_i;
        rsp_d.rs1_ready = rs1_ready_i;
        rsp_d.rs2_ready = rs2_ready_i;
        rsp_d.prd       = rd_is_x0 ? '0 : alloc_preg_i;
        rsp_d.old_prd   = rd_is_x0 ? '0 : map_rd_i;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    if (fire_o) state_q <= ACKED;
                // Drop ack one edge after req goes away
                ACKED:   if (!req_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Payload only, qualified by ack
    always_ff @(posedge clk_i) begin
        if (fire_o) begin
            rsp_q <= rsp_d;
        end
    end

    assign ack_o = (state_q == ACKED);
    assign rsp_o = rsp_q;

    // Phase order, ack only follows a request
    a_ack_needs_req: assert property (
        @(posedge clk_i) disable iff (reset_i) (!ack_o && !req_i) |=> !ack_o
    ) else $error("ack rose without req");

endmodule

`default_nettype wire

// File: design/rename_unit.sv
// Register rename stage, single issue
// Decode hands one instruction over a four-phase req/ack handshake
// Returns source mappings with ready bits, a new destination register
// and the old destination mapping for the reorder buffer to free
// Writeback strobes clear busy bits, commit strobes refill the free list
`timescale 1ns/1ps
`default_nettype none

module rename_unit (
    input  wire                      clk_i,
    input  wire                      reset_i,
    input  wire                      req_i,
    input  rename_pkg::rename_req_t  req_data_i,
    input  rename_pkg::preg_strobe_t wb_i,
    input  rename_pkg::preg_strobe_t free_i,
    output logic                     ack_o,
    output rename_pkg::rename_rsp_t  rsp_o
);

    // Controller strobes
    logic fire;
    logic alloc;

    // Free list head
    logic              fl_empty;
    rename_pkg::preg_t head_preg;

    // Alias table lookups
    rename_pkg::preg_t map_rs1;
    rename_pkg::preg_t map_rs2;
    rename_pkg::preg_t map_rd;

    // Busy table readiness
    logic rs1_ready;
    logic rs2_ready;

    rename_ctrl u_rename_ctrl (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req_i        (req_i),
        .req_data_i   (req_data_i),
        .fl_empty_i   (fl_empty),
        .alloc_preg_i (head_preg),
        .map_rs1_i    (map_rs1),
        .map_rs2_i    (map_rs2),
        .map_rd_i     (map_rd),
        .rs1_ready_i  (rs1_ready),
        .rs2_ready_i  (rs2_ready),
        .ack_o        (ack_o),
        .rsp_o        (rsp_o),
        .fire_o       (fire),
        .alloc_o      (alloc)
    );

    // Commit frees go straight in at the tail
    free_list u_free_list (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .alloc_i     (alloc),
        .free_i      (free_i),
        .empty_o     (fl_empty),
        .head_preg_o (head_preg)
    );

    // x0 write filtering happens inside the table
    map_table u_map_table (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_i      (req_data_i.rs1),
        .rs2_i      (req_data_i.rs2),
        .rd_i       (req_data_i.rd),
        .we_i       (fire),
        .wdata_i    (head_preg),
        .rs1_preg_o (map_rs1),
        .rs2_preg_o (map_rs2),
        .rd_preg_o  (map_rd)
    );

    busy_table u_busy_table (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .set_i       (alloc),
        .set_preg_i  (head_preg),
        .wb_i        (wb_i),
        .rd1_preg_i  (map_rs1),
        .rd2_preg_i  (map_rs2),
        .rd1_ready_o (rs1_ready),
        .rd2_ready_o (rs2_ready)
    );

endmodule

`default_nettype wire

// File: bench/rename_unit_tb.sv
// Testbench for the rename stage
// Runs a hand-written table of renames and strobes, then drains the free
// list to check back-pressure, then 200 random operations
// Responses are compared with a model of the alias table, busy bits and free FIFO
`timescale 1ns/1ps
`default_nettype none

module rename_unit_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int ACK_LIMIT    = 20;
    localparam int TABLE_LEN    = 11;
    localparam int NUM_RANDOM   = 200;
    localparam int WATCHDOG_NS  = (TABLE_LEN + NUM_RANDOM) * 20 * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'h2295_354b;

    typedef enum logic [1:0] {
        OP_RENAME,
        OP_WB,
        OP_FREE,
        OP_RENAME_WB
    } op_t;

    // preg is the strobe target for WB, FREE and RENAME_WB rows
    typedef struct packed {
        op_t                     op;
        rename_pkg::rename_req_t req;
        rename_pkg::preg_t       preg;
        rename_pkg::rename_rsp_t exp;
    } step_t;

    logic                     clk_i;
    logic                     reset_i;
    logic                     req_i;
    rename_pkg::rename_req_t  req_data_i;
    rename_pkg::preg_strobe_t wb_i;
    rename_pkg::preg_strobe_t free_i;
    logic                     ack_o;
    rename_pkg::rename_rsp_t  rsp_o;

    step_t steps [TABLE_LEN];

    // Reference model state
    rename_pkg::preg_t                model_map [rename_pkg::NUM_AREGS];
    logic [rename_pkg::NUM_PREGS-1:0] model_busy;
    rename_pkg::preg_t                model_free [$];
    rename_pkg::preg_t                retire_q [$];

    int errors;
    int checks;

    rename_unit u_rename_unit (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .req_i      (req_i),
        .req_data_i (req_data_i),
        .wb_i       (wb_i),
        .free_i     (free_i),
        .ack_o      (ack_o),
        .rsp_o      (rsp_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("FAIL %s: expected 0x%0h, got 0x%0h", name, exp, got);
        end
    endtask

    task automatic check_rsp(input string tag, input rename_pkg::rename_rsp_t exp,
                             input rename_pkg::rename_rsp_t got);
        check_value($sformatf("%s rsp_o.prs1", tag), 32'(exp.prs1), 32'(got.prs1));
        check_value($sformatf("%s rsp_o.prs2", tag), 32'(exp.prs2), 32'(got.prs2));
        check_value($sformatf("%s rsp_o.rs1_ready", tag), 32'(exp.rs1_ready),
                    32'(got.rs1_ready));
        check_value($sformatf("%s rsp_o.rs2_ready", tag), 32'(exp.rs2_ready),
                    32'(got.rs2_ready));
        check_value($sformatf("%s rsp_o.prd", tag), 32'(exp.prd), 32'(got.prd));
        check_value($sformatf("%s rsp_o.old_prd", tag), 32'(exp.old_prd), 32'(got.old_prd));
    endtask

    function automatic rename_pkg::rename_rsp_t make_rsp(int prs1, int prs2, bit r1, bit r2,
                                                         int prd, int old_prd);
        rename_pkg::rename_rsp_t r;
        r.prs1      = rename_pkg::preg_t'(prs1);
        r.prs2      = rename_pkg::preg_t'(prs2);
        r.rs1_ready = r1;
        r.rs2_ready = r2;
        r.prd       = rename_pkg::preg_t'(prd);
        r.old_prd   = rename_pkg::preg_t'(old_prd);
        return r;
    endfunction

    function automatic step_t make_step(op_t op, int rs1, int rs2, int rd, int preg,
                                        rename_pkg::rename_rsp_t exp);
        step_t s;
        s.op      = op;
        s.req.rs1 = rename_pkg::areg_t'(rs1);
        s.req.rs2 = rename_pkg::areg_t'(rs2);
        s.req.rd  = rename_pkg::areg_t'(rd);
        s.preg    = rename_pkg::preg_t'(preg);
        s.exp     = exp;
        return s;
    endfunction

    // Expected values worked out by hand from reset state
    task automatic build_table();
        // First rename gets p1 while x3 and x0 stay on p0
        steps[0]  = make_step(OP_RENAME,    3, 0, 5, 0, make_rsp(0, 0, 1, 1, 1, 0));
        // Both sources depend on p1 which is not yet written back
        steps[1]  = make_step(OP_RENAME,    5, 5, 6, 0, make_rsp(1, 1, 0, 0, 2, 0));
        // rd equals rs1 so the source sees the older p2
        steps[2]  = make_step(OP_RENAME,    6, 1, 6, 0, make_rsp(2, 0, 0, 1, 3, 2));
        steps[3]  = make_step(OP_WB,        0, 0, 0, 1, '0);
        steps[4]  = make_step(OP_RENAME,    5, 6, 7, 0, make_rsp(1, 3, 1, 0, 4, 0));
        // Writeback of p4 in the fire cycle makes it ready through the bypass
        steps[5]  = make_step(OP_RENAME_WB, 7, 5, 8, 4, make_rsp(4, 1, 1, 1, 5, 0));
        // x0 destination allocates nothing
        steps[6]  = make_step(OP_RENAME,    7, 8, 0, 0, make_rsp(4, 5, 1, 0, 0, 0));
        // Next real rename takes p6 which x0 skipped
        steps[7]  = make_step(OP_RENAME,    0, 0, 9, 0, make_rsp(0, 0, 1, 1, 6, 0));
        steps[8]  = make_step(OP_RENAME,    9, 0, 5, 0, make_rsp(6, 0, 0, 1, 7, 1));
        steps[9]  = make_step(OP_WB,        0, 0, 0, 6, '0);
        steps[10] = make_step(OP_RENAME,    9, 5, 10, 0, make_rsp(6, 7, 1, 0, 8, 0));
    endtask

    function automatic logic model_ready(rename_pkg::preg_t p, logic wb_en,
                                         rename_pkg::preg_t wb_p);
        return (p == '0) || !model_busy[p] || (wb_en && (wb_p == p));
    endfunction

    function automatic rename_pkg::rename_rsp_t predict(rename_pkg::rename_req_t rq,
                                                        logic wb_en, rename_pkg::preg_t wb_p);
        rename_pkg::rename_rsp_t r;
        r.prs1      = model_map[rq.rs1];
        r.prs2      = model_map[rq.rs2];
        r.rs1_ready = model_ready(r.prs1, wb_en, wb_p);
        r.rs2_ready = model_ready(r.prs2, wb_en, wb_p);
        r.prd       = (rq.rd == '0) ? '0 : model_free[0];
        r.old_prd   = (rq.rd == '0) ? '0 : model_map[rq.rd];
        return r;
    endfunction

    task automatic apply_to_model(input rename_pkg::rename_req_t rq, input logic wb_en,
                                  input rename_pkg::preg_t wb_p,
                                  input rename_pkg::rename_rsp_t r);
        if (wb_en) begin
            model_busy[wb_p] = 1'b0;
        end
        // Allocation set wins over a writeback in the same cycle
        if (rq.rd != '0) begin
            void'(model_free.pop_front());
            model_busy[r.prd] = 1'b1;
            model_map[rq.rd]  = r.prd;
            if (r.old_prd != '0) begin
                retire_q.push_back(r.old_prd);
            end
        end
    endtask

    // Oldest retired register that is neither mapped nor already free
    task automatic take_retirable(output rename_pkg::preg_t p, output bit found);
        bit live;
        found = 1'b0;
        p     = '0;
        while (!found && retire_q.size() > 0) begin
            p    = retire_q.pop_front();
            live = 1'b0;
            foreach (model_map[i]) begin
                if (model_map[i] == p) begin
                    live = 1'b1;
                end
            end
            foreach (model_free[i]) begin
                if (model_free[i] == p) begin
                    live = 1'b1;
                end
            end
            found = !live;
        end
    endtask

    task automatic pulse_wb(input rename_pkg::preg_t p);
        wb_i.en   = 1'b1;
        wb_i.preg = p;
        next_cycle();
        wb_i = '0;
        model_busy[p] = 1'b0;
    endtask

    task automatic pulse_free(input rename_pkg::preg_t p);
        free_i.en   = 1'b1;
        free_i.preg = p;
        next_cycle();
        free_i = '0;
        model_free.push_back(p);
    endtask

    // Raise req with an optional writeback lined up with the fire cycle
    task automatic start_rename(input rename_pkg::rename_req_t rq, input logic wb_en,
                                input rename_pkg::preg_t wb_p);
        req_data_i = rq;
        req_i      = 1'b1;
        wb_i.en    = wb_en;
        wb_i.preg  = wb_p;
        next_cycle();
        wb_i = '0;
    endtask

    // Remaining handshake phases with each wait bounded by ACK_LIMIT cycles
    task automatic finish_rename(input string tag, input rename_pkg::rename_rsp_t exp);
        int waited;
        waited = 0;
        while (ack_o !== 1'b1 && waited < ACK_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (ack_o !== 1'b1) begin
            errors++;
            $display("%s: ack never rose", tag);
        end else begin
            check_rsp(tag, exp, rsp_o);
        end
        req_i  = 1'b0;
        waited = 0;
        next_cycle();
        while (ack_o !== 1'b0 && waited < ACK_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (ack_o !== 1'b0) begin
            errors++;
            $display("%s: ack never fell after req dropped", tag);
        end
    endtask

    task automatic do_rename(input string tag, input rename_pkg::rename_req_t rq,
                             input logic wb_en, input rename_pkg::preg_t wb_p,
                             input rename_pkg::rename_rsp_t exp);
        start_rename(rq, wb_en, wb_p);
        finish_rename(tag, exp);
        apply_to_model(rq, wb_en, wb_p, exp);
    endtask

    // Watchdog sized from the number of operations
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run still going after %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rename_pkg::rename_req_t rq;
        rename_pkg::rename_rsp_t exp;
        rename_pkg::preg_t       p;
        rename_pkg::preg_t       order [3];
        logic                    wb_en;
        bit                      found;
        bit                      stalled;
        int                      sel;
        int                      fill;

        void'($urandom(SEED));
        errors      = 0;
        checks      = 0;
        reset_i     = 1'b1;
        req_i       = 1'b0;
        req_data_i  = '0;
        wb_i        = '0;
        free_i      = '0;
        foreach (model_map[i]) model_map[i] = '0;
        model_busy = '0;
        for (int i = 1; i < rename_pkg::NUM_PREGS; i++) begin
            model_free.push_back(rename_pkg::preg_t'(i));
        end
        build_table();

        repeat (RESET_CYCLES) @(posedge clk_i);
        #1 reset_i = 1'b0;

        // Apply the hand table and cross-check the model on each row
        for (int s = 0; s < TABLE_LEN; s++) begin
            case (steps[s].op)
                OP_WB:   pulse_wb(steps[s].preg);
                OP_FREE: pulse_free(steps[s].preg);
                default: begin
                    wb_en = (steps[s].op == OP_RENAME_WB);
                    exp   = predict(steps[s].req, wb_en, steps[s].preg);
                    check_rsp($sformatf("model step %0d", s), steps[s].exp, exp);
                    do_rename($sformatf("step %0d", s), steps[s].req, wb_en,
                              steps[s].preg, steps[s].exp);
                end
            endcase
        end

        // Drain the free list with no frees
        fill = 0;
        while (model_free.size() > 0) begin
            rq.rs1 = rename_pkg::areg_t'(fill % 31 + 1);
            rq.rs2 = '0;
            rq.rd  = rename_pkg::areg_t'((fill + 7) % 31 + 1);
            do_rename($sformatf("fill %0d", fill), rq, 1'b0, '0, predict(rq, 1'b0, '0));
            fill++;
        end

        // A real destination must stall on an empty list
        rq.rs1 = 5'd1;
        rq.rs2 = 5'd2;
        rq.rd  = 5'd3;
        start_rename(rq, 1'b0, '0);
        stalled = 1'b1;
        for (int c = 0; c < ACK_LIMIT; c++) begin
            if (ack_o) stalled = 1'b0;
            next_cycle();
        end
        if (!stalled) begin
            errors++;
            $display("ack rose while the free list was empty");
        end
        pulse_free(6'd7);
        exp = predict(rq, 1'b0, '0);
        finish_rename("stall", exp);
        apply_to_model(rq, 1'b0, '0, exp);
        check_value("stall rsp_o.prd", 32'd7, 32'(rsp_o.prd));

        // Frees come back in FIFO order
        order = '{6'd9, 6'd3, 6'd12};
        foreach (order[k]) pulse_free(order[k]);
        foreach (order[k]) begin
            rq.rs1 = '0;
            rq.rs2 = '0;
            rq.rd  = rename_pkg::areg_t'(11 + k);
            exp    = predict(rq, 1'b0, '0);
            do_rename($sformatf("order %0d", k), rq, 1'b0, '0, exp);
            check_value($sformatf("order %0d rsp_o.prd", k), 32'(order[k]), 32'(rsp_o.prd));
        end

        // Random operations where frees only return registers no longer in use
        for (int n = 0; n < NUM_RANDOM; n++) begin
            sel    = int'($urandom % 8);
            rq.rs1 = rename_pkg::areg_t'($urandom % 32);
            rq.rs2 = rename_pkg::areg_t'($urandom % 32);
            rq.rd  = rename_pkg::areg_t'($urandom % 32);
            if (sel >= 6) begin
                take_retirable(p, found);
                if (found) pulse_free(p);
                else pulse_wb(rename_pkg::preg_t'($urandom % 63 + 1));
            end else if (sel == 5) begin
                pulse_wb(rename_pkg::preg_t'($urandom % 63 + 1));
            end else begin
                if (model_free.size() == 0) rq.rd = '0;
                // Writeback aimed at rs1 exercises the bypass
                wb_en = (sel == 4);
                p     = model_map[rq.rs1];
                exp   = predict(rq, wb_en, p);
                do_rename($sformatf("random %0d", n), rq, wb_en, p, exp);
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rename_unit.f
design/rename_pkg.sv
design/free_list.sv
design/map_table.sv
design/busy_table.sv
design/rename_ctrl.sv
design/rename_unit.sv
bench/rename_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := rename_unit_tb
FILELIST  := rename_unit.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
